// ==== project.f ====
+incdir+hdl
hdl/fetch_pkg.sv
hdl/imem_port.sv
hdl/fetch_buffer.sv
hdl/rvc_expander.sv
hdl/fetch_unit.sv
tests/tb_imem.sv
tests/tb_fetch_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f project.f --top-module tb_fetch_unit -o sim_fetch

# the run itself may stop with a failing status, the log decides
./obj_dir/sim_fetch > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0

// ==== tests/tb_fetch_unit.sv ====
`timescale 1ns/1ns
`include "fetch_consts.svh"

module tb_fetch_unit;

    // cycle budget per test, summed for the watchdog
    localparam int budget_cycles = 10 + 60 + 120 + 80 + 80 + 80 + 100;

    logic        clk;
    logic        n_rst;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        ex_busy;
    logic        pc_update;
    logic        imem_ack;
    logic [31:0] imem_rdata;
    logic        imem_ren;
    logic [31:0] imem_addr;
    logic        inst_valid;
    logic [31:0] inst_out;
    logic [31:0] inst_pc;
    logic        inst_compressed;
    logic        inst_illegal;

    logic [31:0] img [0:255];  // reference copy of the memory image
    logic [31:0] cursor;       // next free halfword while building a stream
    logic [31:0] exp_pc;       // reference walk position

    fetch_unit uut (
        .clk(clk), .n_rst(n_rst), .redirect(redirect), .redirect_pc(redirect_pc),
        .ex_busy(ex_busy), .pc_update(pc_update), .imem_ack(imem_ack),
        .imem_rdata(imem_rdata), .imem_ren(imem_ren), .imem_addr(imem_addr),
        .inst_valid(inst_valid), .inst_out(inst_out), .inst_pc(inst_pc),
        .inst_compressed(inst_compressed), .inst_illegal(inst_illegal)
    );

    tb_imem mem_model (
        .clk(clk), .n_rst(n_rst), .ren(imem_ren), .addr(imem_addr),
        .ack(imem_ack), .rdata(imem_rdata)
    );

    always #10 clk = ~clk;

    initial begin
        #(budget_cycles * 4 * 20);
        $display("timeout: the fetch unit stopped delivering instructions");
        $display("Simulation finished: FAIL");
        $fatal(1);
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h (pc %h)", name, got, exp, exp_pc);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    // every word defaults to a 32-bit opcode built from its own address
    task automatic clear_image();
        for (int i = 0; i < 256; i++) begin
            img[i] = {22'd0, i[7:0], 2'b11};
        end
    endtask

    task automatic load_image();
        for (int i = 0; i < 256; i++) begin
            mem_model.mem[i] = img[i];
        end
    endtask

    function automatic logic [15:0] half_at(input logic [31:0] a);
        return a[1] ? img[a[9:2]][31:16] : img[a[9:2]][15:0];
    endfunction

    task automatic put_half(input logic [31:0] a, input logic [15:0] h);
        if (a[1]) img[a[9:2]][31:16] = h;
        else img[a[9:2]][15:0] = h;
    endtask

    task automatic emit16(input logic [15:0] h);
        put_half(cursor, h);
        cursor = cursor + 32'd2;
    endtask

    task automatic emit32(input logic [31:0] w);
        put_half(cursor, w[15:0]);
        put_half(cursor + 32'd2, w[31:16]);
        cursor = cursor + 32'd4;
    endtask

    // addi x1, x1, k
    function automatic logic [31:0] i32(input int k);
        return {k[11:0], 5'd1, 3'b000, 5'd1, 7'b0010011};
    endfunction

    function automatic logic [15:0] c_ci(input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [5:0] imm);
        return {f3, imm[5], rd, imm[4:0], 2'b01};
    endfunction

    function automatic logic [15:0] c_cr(input logic b12, input logic [4:0] rd,
                                         input logic [4:0] rs2);
        return {3'b100, b12, rd, rs2, 2'b10};
    endfunction

    // {illegal, 32-bit form} of a compressed parcel, from the isa spec
    function automatic logic [32:0] expand(input logic [15:0] h);
        logic [11:0] imm;
        imm = {{7{h[12]}}, h[6:2]};
        if (h[1:0] == 2'b01 && h[15:13] == 3'b000)
            return {1'b0, imm, h[11:7], 3'b000, h[11:7], 7'b0010011};  // c.addi
        if (h[1:0] == 2'b01 && h[15:13] == 3'b010)
            return {1'b0, imm, 5'd0, 3'b000, h[11:7], 7'b0010011};     // c.li
        if (h[1:0] == 2'b10 && h[15:13] == 3'b100 && h[6:2] != 5'd0) begin
            if (!h[12])
                return {1'b0, 7'd0, h[6:2], 5'd0, 3'b000, h[11:7], 7'b0110011};
            return {1'b0, 7'd0, h[6:2], h[11:7], 3'b000, h[11:7], 7'b0110011};
        end
        return {1'b1, 16'd0, h};
    endfunction

    // compare the instruction on the outputs right now against the walk
    task automatic compare_delivered();
        logic [15:0] h;
        logic [32:0] e;
        h = half_at(exp_pc);
        check_value("inst_pc", inst_pc, exp_pc);
        if (h[1:0] != 2'b11) begin
            e = expand(h);
            check_value("inst_compressed", {31'd0, inst_compressed}, 32'd1);
            check_value("inst_out", inst_out, e[31:0]);
            check_value("inst_illegal", {31'd0, inst_illegal}, {31'd0, e[32]});
            exp_pc = exp_pc + 32'd2;
        end else begin
            check_value("inst_compressed", {31'd0, inst_compressed}, 32'd0);
            check_value("inst_out", inst_out, {half_at(exp_pc + 32'd2), h});
            check_value("inst_illegal", {31'd0, inst_illegal}, 32'd0);
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    // wait for the next delivered instruction and compare against the walk
    task automatic check_next();
        do @(negedge clk); while (!inst_valid);
        compare_delivered();
    endtask

    task automatic do_redirect(input logic [31:0] target);
        @(posedge clk);
        redirect    <= 1'b1;
        redirect_pc <= target;
        @(posedge clk);
        redirect <= 1'b0;
        exp_pc = target;
    endtask

    task automatic test_reset_stream();
        repeat (6) check_next();  // image was loaded before reset release
    endtask

    task automatic test_mixed_stream();
        clear_image();
        cursor = 32'h200;
        emit16(c_ci(3'b010, 5'd3, 6'd7));
        emit16(c_ci(3'b000, 5'd3, 6'd1));
        emit32(i32(11));
        emit16(c_cr(1'b0, 5'd4, 5'd3));
        emit32(i32(12));               // straddles
        emit32(i32(13));               // straddles again
        emit16(c_cr(1'b1, 5'd4, 5'd4));
        emit16(c_ci(3'b010, 5'd8, 6'h3f));
        emit32(i32(14));
        emit16(c_ci(3'b000, 5'd9, 6'd2));
        emit32(i32(15));
        load_image();
        do_redirect(32'h200);
        repeat (11) check_next();
    endtask

    // target ends in 2 while a read is outstanding
    task automatic test_redirect_in_flight();
        clear_image();
        cursor = 32'h280;
        emit16(16'h4188);              // must never show up
        emit32(i32(21));
        emit16(c_ci(3'b010, 5'd5, 6'd5));
        emit16(c_ci(3'b010, 5'd6, 6'd6));
        emit32(i32(22));
        load_image();
        do @(negedge clk); while (!imem_ren);
        do_redirect(32'h282);
        do @(negedge clk); while (!imem_ren);  // stale read swallowed, target word next
        check_value("imem_addr", imem_addr, 32'h280);
        repeat (6) check_next();
    endtask

    // target ends in 2 with no read outstanding
    task automatic test_redirect_idle();
        clear_image();
        cursor = 32'h2c0;
        emit16(16'h4188);
        emit16(c_ci(3'b000, 5'd7, 6'd3));
        emit32(i32(31));
        emit16(c_cr(1'b0, 5'd2, 5'd7));
        load_image();
        @(posedge clk);
        ex_busy <= 1'b1;
        repeat (8) @(posedge clk);     // any old response is back by now
        do_redirect(32'h2c2);
        ex_busy <= 1'b0;
        @(negedge clk);                // read of the target word one cycle later
        check_value("imem_ren", {31'd0, imem_ren}, 32'd1);
        check_value("imem_addr", imem_addr, 32'h2c0);
        repeat (5) check_next();
    endtask

    task automatic test_expansion();
        clear_image();
        cursor = 32'h240;
        emit16(c_ci(3'b000, 5'd5, 6'h3d)); // c.addi x5, -3
        emit16(c_ci(3'b010, 5'd6, 6'h1f));
        emit16(c_cr(1'b0, 5'd7, 5'd6));    // c.mv
        emit16(c_cr(1'b1, 5'd7, 5'd5));    // c.add
        emit16(16'h4188);                  // c.lw, unsupported
        emit16(16'h8082);                  // c.jr ra
        emit16(16'h6505);                  // c.lui
        emit32(i32(41));
        load_image();
        do_redirect(32'h240);
        repeat (8) check_next();
    endtask

    task automatic test_back_pressure();
        clear_image();
        cursor = 32'h300;
        for (int i = 0; i < 8; i++) begin
            emit16(c_ci(3'b010, 5'(i + 1), 6'(i)));
        end
        load_image();
        do_redirect(32'h300);
        check_next();                      // low half of a pair
        @(posedge clk);
        ex_busy <= 1'b1;
        repeat (10) begin
            @(negedge clk);
            check_value("imem_ren", {31'd0, imem_ren}, 32'd0);
            check_value("inst_valid", {31'd0, inst_valid}, 32'd0);
        end
        @(posedge clk);
        ex_busy <= 1'b0;
        @(negedge clk);                    // buffered high half, early path
        check_value("inst_valid", {31'd0, inst_valid}, 32'd1);
        check_value("imem_ren", {31'd0, imem_ren}, 32'd0);
        compare_delivered();
        repeat (6) check_next();
    endtask

    initial begin
        clk         = 1'b0;
        n_rst       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        ex_busy     = 1'b0;
        pc_update   = 1'b1;
        clear_image();
        for (int i = 0; i < 6; i++) begin
            img[(`RESET_PC >> 2) + i] = i32(i + 1);
        end
        load_image();
        exp_pc = `RESET_PC;
        repeat (5) @(posedge clk);
        n_rst <= 1'b1;

        test_reset_stream();
        test_mixed_stream();
        test_redirect_in_flight();
        test_redirect_idle();
        test_expansion();
        test_back_pressure();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== tests/tb_imem.sv ====
`timescale 1ns/1ns

module tb_imem (
    input  logic        clk,
    input  logic        n_rst,
    input  logic        ren,
    input  logic [31:0] addr,
    output logic        ack,
    output logic [31:0] rdata
);

    localparam logic [15:0] lfsr_seed = 16'd50580;

    logic [31:0] mem [0:255];  // filled by the testbench, wraps every 1 KiB
    logic [15:0] lfsr;
    logic [15:0] lfsr_mid;     // state after the first bit is taken
    logic [2:0]  cnt;          // cycles left until ack, 0 = idle
    logic [31:0] addr_q;

    // galois lfsr, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    assign lfsr_mid = lfsr_next(lfsr);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            ack   <= 1'b0;
            rdata <= '0;
            cnt   <= '0;
            addr_q <= '0;
            lfsr  <= lfsr_seed;
        end else begin
            ack <= 1'b0;  // one-cycle pulse
            if (ren) begin
                // two bits taken, latency 1 to 4
                cnt    <= {1'b0, lfsr_mid[0], lfsr[0]} + 3'd1;
                lfsr   <= lfsr_next(lfsr_mid);
                addr_q <= addr;
            end else if (cnt != 3'd0) begin
                if (cnt == 3'd1) begin
                    ack   <= 1'b1;
                    rdata <= mem[addr_q[9:2]];
                end
                cnt <= cnt - 3'd1;
            end
        end
    end

endmodule

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ns
`include "fetch_consts.svh"

module fetch_unit import fetch_pkg::*; (
    input  logic             clk,
    input  logic             n_rst,
    input  logic             redirect,
    input  logic [`XLEN-1:0] redirect_pc,
    input  logic             ex_busy,
    input  logic             pc_update,
    input  logic             imem_ack,
    input  logic [`XLEN-1:0] imem_rdata,
    output logic             imem_ren,
    output logic [`XLEN-1:0] imem_addr,
    output logic             inst_valid,
    output logic [`XLEN-1:0] inst_out,
    output logic [`XLEN-1:0] inst_pc,
    output logic             inst_compressed,
    output logic             inst_illegal
);

    fetch_word_t      inst_word;     // word from memory, split by the buffer
    logic             inst_arrived;
    logic             done_earlier;
    logic [`XLEN-1:0] imem_pc;
    logic [`XLEN-1:0] raw_inst;      // realigned, not yet expanded

    imem_port u_port (
        .clk          (clk),
        .n_rst        (n_rst),
        .redirect     (redirect),
        .ex_busy      (ex_busy),
        .done_earlier (done_earlier),
        .imem_pc      (imem_pc),
        .imem_ack     (imem_ack),
        .imem_rdata   (imem_rdata),
        .imem_ren     (imem_ren),
        .imem_addr    (imem_addr),
        .inst_arrived (inst_arrived),
        .inst         (inst_word)
    );

    fetch_buffer u_buf (
        .clk          (clk),
        .n_rst        (n_rst),
        .reset_en     (redirect),
        .reset_pc     (redirect_pc),
        .inst_arrived (inst_arrived),
        .inst         (inst_word),
        .ex_busy      (ex_busy),
        .pc_update    (pc_update),
        .imem_pc      (imem_pc),
        .done_earlier (done_earlier),
        .done         (inst_valid),
        .pc           (inst_pc),
        .result       (raw_inst),
        .compressed   (inst_compressed)
    );

    rvc_expander u_rvc (
        .raw_inst   (raw_inst),
        .compressed (inst_compressed),
        .expanded   (inst_out),
        .illegal    (inst_illegal)
    );

endmodule

// ==== hdl/rvc_expander.sv ====
`timescale 1ns/1ns
`include "fetch_consts.svh"

module rvc_expander import fetch_pkg::*; (
    input  logic [`XLEN-1:0] raw_inst,   // upper half zero when compressed
    input  logic             compressed,
    output logic [`XLEN-1:0] expanded,
    output logic             illegal
);

    rvc_quad_t   quad;
    rvc_f3_t     f3;
    logic [4:0]  rd;      // rd/rs1 field, full register number
    logic [4:0]  rs2;
    logic [5:0]  imm6;    // ci-format immediate
    logic [11:0] imm12;
    logic        mv_sel;  // bit 12 low means c.mv, high means c.add

    assign quad   = rvc_quad_t'(raw_inst[1:0]);
    assign f3     = rvc_f3_t'(raw_inst[15:13]);
    assign rd     = raw_inst[11:7];
    assign rs2    = raw_inst[6:2];
    assign imm6   = {raw_inst[12], raw_inst[6:2]};
    assign imm12  = {{6{imm6[5]}}, imm6}; // sign extend
    assign mv_sel = ~raw_inst[12];

    always_comb begin
        expanded = raw_inst;  // 32-bit insts go through untouched
        illegal  = 1'b0;

        if (compressed) begin
            // anything not matched below stays the raw parcel, flagged
            expanded = {{`PARCEL_W{1'b0}}, raw_inst[`PARCEL_W-1:0]};
            illegal  = 1'b1;

            case (quad)
                q1: begin
                    case (f3)
                        f3_addi: begin
                            // addi rd, rd, imm
                            expanded = {imm12, rd, 3'b000, rd, opc_op_imm};
                            illegal  = 1'b0;
                        end
                        f3_li: begin
                            // addi rd, x0, imm
                            expanded = {imm12, 5'd0, 3'b000, rd, opc_op_imm};
                            illegal  = 1'b0;
                        end
                        default: begin
                            illegal = 1'b1;
                        end
                    endcase
                end
                q2: begin
                    // rs2 of zero would be c.jr / c.jalr / c.ebreak
                    if (f3 == f3_mv_add && rs2 != 5'd0) begin
                        if (mv_sel) begin
                            // add rd, x0, rs2
                            expanded = {7'b0000000, rs2, 5'd0, 3'b000, rd, opc_op};
                        end else begin
                            // add rd, rd, rs2
                            expanded = {7'b0000000, rs2, rd, 3'b000, rd, opc_op};
                        end
                        illegal = 1'b0;
                    end
                end
                default: begin
                    illegal = 1'b1; // q0 and the rest of the set
                end
            endcase
        end
    end

endmodule

// ==== hdl/fetch_buffer.sv ====
`timescale 1ns/1ns
`include "fetch_consts.svh"

module fetch_buffer import fetch_pkg::*; (
    input  logic             clk,
    input  logic             n_rst,
    input  logic             reset_en,     // redirect strobe
    input  logic [`XLEN-1:0] reset_pc,     // target, may end in 2
    input  logic             inst_arrived,
    input  fetch_word_t      inst,
    input  logic             ex_busy,
    input  logic             pc_update,
    output logic [`XLEN-1:0] imem_pc,      // address of the next word needed
    output logic             done_earlier, // buffered parcel goes out with no read
    output logic             done,         // an instruction leaves this cycle
    output logic [`XLEN-1:0] pc,           // pc of that instruction
    output logic [`XLEN-1:0] result,       // upper half zero when compressed
    output logic             compressed
);

    localparam logic [`XLEN-1:0] boot_pc = `RESET_PC;

    logic [`PARCEL_W-1:0] parcel;      // high half of the last word
    logic                 combine_q;   // parcel is the low part of a 32-bit inst
    logic                 wait_q;      // parcel is a whole compressed inst not yet sent
    logic                 realign_q;   // first word after a redirect to pc+2
    logic                 early_q;     // early delivery window after an arrival

    logic [`PARCEL_W-1:0] next_parcel;
    logic [`XLEN-1:0]     next_pc;
    logic [`XLEN-1:0]     next_imem_pc;
    logic                 combine;
    logic                 wait_next;
    logic                 finished;
    logic                 short_inst;

    // the window stays open while ex_busy holds the port off, so no read
    // of the same word can be in flight when the early path fires
    assign done_earlier = early_q & wait_q & ~ex_busy & pc_update & ~reset_en;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            pc        <= boot_pc;
            imem_pc   <= word_align(boot_pc);
            combine_q <= 1'b0;
            wait_q    <= 1'b0;
            realign_q <= boot_pc[1];
            early_q   <= 1'b0;
        end else if (reset_en) begin
            pc        <= reset_pc;              // may be halfword aligned
            imem_pc   <= word_align(reset_pc);  // memory only sees words
            combine_q <= 1'b0;
            wait_q    <= 1'b0;
            realign_q <= reset_pc[1];           // low half of first word is junk
            early_q   <= 1'b0;
        end else begin
            early_q <= inst_arrived | (early_q & ex_busy);
            if (inst_arrived || done_earlier) begin
                pc        <= next_pc;
                imem_pc   <= next_imem_pc;
                combine_q <= combine;
                wait_q    <= wait_next;
                realign_q <= 1'b0;
            end
        end
    end

    // parcel store, payload only
    always_ff @(posedge clk) begin
        if (inst_arrived) begin
            parcel <= next_parcel;
        end
    end

    always_comb begin
        next_pc      = pc;
        next_imem_pc = imem_pc;
        next_parcel  = parcel;
        combine      = 1'b0;
        wait_next    = 1'b0;
        finished     = 1'b0;
        short_inst   = 1'b0;
        result       = '0;

        if (done_earlier) begin
            // second compressed inst of a pair, straight from the buffer
            result       = {{`PARCEL_W{1'b0}}, parcel};
            next_pc      = pc + `PARCEL_BYTES;
            next_imem_pc = imem_pc + `WORD_BYTES;
            finished     = 1'b1;
            short_inst   = 1'b1;
        end else if (inst_arrived) begin
            if (realign_q) begin
                next_imem_pc = imem_pc + `WORD_BYTES;
                if (is_rvc(inst.parcel[1])) begin
                    result     = {{`PARCEL_W{1'b0}}, inst.parcel[1]};
                    next_pc    = pc + `PARCEL_BYTES;
                    finished   = 1'b1;
                    short_inst = 1'b1;
                end else begin
                    combine     = 1'b1;             // target straddles into next word
                    next_parcel = inst.parcel[1];
                end
            end else if (combine_q) begin
                // straddling inst completes with the low half of this word
                result      = {inst.parcel[0], parcel};
                next_pc     = pc + `WORD_BYTES;
                finished    = 1'b1;
                next_parcel = inst.parcel[1];
                if (is_rvc(inst.parcel[1])) begin
                    wait_next = 1'b1;               // keep imem_pc, parcel still owed
                end else begin
                    combine      = 1'b1;
                    next_imem_pc = imem_pc + `WORD_BYTES;
                end
            end else if (wait_q) begin
                // early path was missed, the refetched word is dropped
                result       = {{`PARCEL_W{1'b0}}, parcel};
                next_pc      = pc + `PARCEL_BYTES;
                next_imem_pc = imem_pc + `WORD_BYTES;
                finished     = 1'b1;
                short_inst   = 1'b1;
            end else if (is_rvc(inst.parcel[0])) begin
                result      = {{`PARCEL_W{1'b0}}, inst.parcel[0]};
                next_pc     = pc + `PARCEL_BYTES;
                finished    = 1'b1;
                short_inst  = 1'b1;
                next_parcel = inst.parcel[1];
                if (is_rvc(inst.parcel[1])) begin
                    wait_next = 1'b1;               // pair in one word
                end else begin
                    combine      = 1'b1;
                    next_imem_pc = imem_pc + `WORD_BYTES;
                end
            end else begin
                result       = inst.full;           // aligned 32-bit inst
                next_pc      = pc + `WORD_BYTES;
                next_imem_pc = imem_pc + `WORD_BYTES;
                finished     = 1'b1;
            end
        end
    end

    assign done       = finished;
    assign compressed = short_inst;

endmodule

// ==== hdl/imem_port.sv ====
`timescale 1ns/1ns
`include "fetch_consts.svh"

module imem_port import fetch_pkg::*; (
    input  logic             clk,
    input  logic             n_rst,
    input  logic             redirect,     // one-cycle strobe
    input  logic             ex_busy,      // holds off new reads
    input  logic             done_earlier, // buffer drained a parcel without memory
    input  logic [`XLEN-1:0] imem_pc,      // next word the buffer needs
    input  logic             imem_ack,
    input  logic [`XLEN-1:0] imem_rdata,
    output logic             imem_ren,
    output logic [`XLEN-1:0] imem_addr,
    output logic             inst_arrived,
    output logic [`XLEN-1:0] inst
);

    logic boot_q;     // low only in the first cycle after reset release
    logic want_q;     // a read is owed to the buffer
    logic pending_q;  // one request outstanding
    logic stale_q;    // outstanding request was overtaken by a redirect
    logic ack_ok;
    logic launch;
    logic trigger;

    // a response is good only if nothing redirected us since it was issued
    assign ack_ok       = imem_ack & pending_q & ~stale_q & ~redirect;
    assign inst_arrived = ack_ok;
    assign inst         = imem_rdata; // data is only looked at with inst_arrived

    // events that owe the buffer a fresh read
    assign trigger = ack_ok | redirect | done_earlier | ~boot_q;

    // no launch in a cycle where the buffer is still moving imem_pc
    assign launch = want_q & ~pending_q & ~ex_busy & ~redirect & ~done_earlier;

    assign imem_ren  = launch;
    assign imem_addr = word_align(imem_pc);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            boot_q    <= 1'b0;
            want_q    <= 1'b0;
            pending_q <= 1'b0;
            stale_q   <= 1'b0;
        end else begin
            boot_q <= 1'b1;

            if (launch) begin
                want_q <= 1'b0;
            end
            if (trigger) begin   // trigger wins, it never overlaps a launch anyway
                want_q <= 1'b1;
            end

            if (launch) begin
                pending_q <= 1'b1;
            end else if (imem_ack) begin
                pending_q <= 1'b0; // stale or not, the slot is free again
            end

            if (imem_ack) begin
                stale_q <= 1'b0;
            end else if (redirect && pending_q) begin
                stale_q <= 1'b1; // swallow whatever comes back
            end
        end
    end

endmodule

// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

`include "fetch_consts.svh"

    // one memory word, seen whole or as two parcels (index 0 = low half)
    typedef union packed {
        logic [`XLEN-1:0]                 full;
        logic [1:0][`PARCEL_W-1:0]        parcel;
    } fetch_word_t;

    // quadrant field, bits [1:0] of every instruction
    typedef enum logic [1:0] {
        q0     = 2'b00,
        q1     = 2'b01,
        q2     = 2'b10,
        q_full = 2'b11   // not compressed
    } rvc_quad_t;

    // funct3 values of the supported compressed ops
    typedef enum logic [2:0] {
        f3_addi   = 3'b000, // q1
        f3_li     = 3'b010, // q1
        f3_mv_add = 3'b100  // q2, bit 12 picks mv or add
    } rvc_f3_t;

    // 32-bit major opcodes the expander produces
    typedef enum logic [6:0] {
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011
    } rv_opcode_t;

    // a parcel starts a compressed instruction unless its quadrant is 3
    function automatic logic is_rvc(input logic [`PARCEL_W-1:0] p);
        return rvc_quad_t'(p[1:0]) != q_full;
    endfunction

    // drop the byte offset of an address
    function automatic logic [`XLEN-1:0] word_align(input logic [`XLEN-1:0] a);
        return {a[`XLEN-1:2], 2'b00};
    endfunction

endpackage

// ==== hdl/fetch_consts.svh ====
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// datapath and address width
`define XLEN 32

// one compressed instruction parcel
`define PARCEL_W 16

// byte steps for pc and fetch address
`define WORD_BYTES 4
`define PARCEL_BYTES 2

// pc and fetch address out of reset, word aligned
`define RESET_PC 32'h0000_0100

`endif
